//--- flist.f
logic/ilkn_rx_pkg.sv
logic/channel_filter.sv
logic/word_packer.sv
logic/rx_channel_demux.sv
verif/demux_checker.sv
verif/tb_rx_channel_demux.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f flist.f --top-module tb_rx_channel_demux \
		--Mdir obj_dir -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verif/tb_rx_channel_demux.sv
////////////////////
// testbench for the receive channel demux
// drives a table of word kinds per slot, one test after another
// demux_checker does the comparing, the counts are reported here
////////////////////

module tb_rx_channel_demux
	import ilkn_rx_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [2:0] K_DATA = 3'd0;
	localparam logic [2:0] K_BA = 3'd1;
	localparam logic [2:0] K_BB = 3'd2;
	localparam logic [2:0] K_BO = 3'd3;
	localparam logic [2:0] K_IDLE = 3'd4;
	localparam chan_id_t CHAN_OTHER = 8'h07;
	localparam int MAX_ROWS = 32;
	localparam int NUM_TESTS = 6;
	localparam int DRAIN_LIMIT = 100;

	logic        clk;
	logic        arst;
	logic        lanes_valid;
	lane_group_t lanes;
	logic        page_a_valid;
	lane_group_t page_a;
	logic        page_b_valid;
	lane_group_t page_b;
	logic        done;
	int          error_count;
	int          word_count;

	////////////////////
	// stimulus table
	////////////////////

	int         row_total;
	int         row_test [MAX_ROWS];
	logic       row_valid [MAX_ROWS];
	logic [2:0] row_kind [MAX_ROWS][NUM_WORDS];
	logic       row_sop [MAX_ROWS];
	logic [3:0] row_eop [MAX_ROWS];
	string      test_name [NUM_TESTS] = '{"single A burst", "interleaved A and B",
		"sop and eop masks", "A restarts A", "invalid cycles", "packer remainders"};

	// kinds in arrival order, k3 first
	task automatic add_row(input int t, input logic v, input logic [2:0] k3,
		input logic [2:0] k2, input logic [2:0] k1, input logic [2:0] k0,
		input logic sop, input logic [3:0] eop);
		row_test[row_total] = t;
		row_valid[row_total] = v;
		row_kind[row_total][3] = k3;
		row_kind[row_total][2] = k2;
		row_kind[row_total][1] = k1;
		row_kind[row_total][0] = k0;
		row_sop[row_total] = sop;
		row_eop[row_total] = eop;
		row_total++;
	endtask

	task automatic build_table();
		row_total = 0;
		add_row(0, 1'b1, K_BA, K_DATA, K_DATA, K_DATA, 1'b1, 4'h0);
		add_row(0, 1'b1, K_DATA, K_DATA, K_DATA, K_DATA, 1'b0, 4'h0);
		add_row(0, 1'b1, K_DATA, K_DATA, K_DATA, K_DATA, 1'b0, 4'h0);
		add_row(0, 1'b1, K_DATA, K_DATA, K_IDLE, K_DATA, 1'b0, 4'h3);
		// B handed over to A inside one group
		add_row(1, 1'b1, K_BB, K_DATA, K_DATA, K_BA, 1'b1, 4'h2);
		add_row(1, 1'b1, K_DATA, K_DATA, K_BB, K_DATA, 1'b1, 4'h1);
		add_row(1, 1'b1, K_DATA, K_BA, K_DATA, K_BB, 1'b0, 4'h5);
		add_row(1, 1'b1, K_DATA, K_IDLE, K_DATA, K_DATA, 1'b0, 4'h7);
		add_row(2, 1'b1, K_BA, K_DATA, K_IDLE, K_BA, 1'b1, 4'hf);
		add_row(2, 1'b1, K_DATA, K_IDLE, K_IDLE, K_DATA, 1'b1, 4'h5);
		add_row(2, 1'b1, K_BA, K_DATA, K_DATA, K_DATA, 1'b0, 4'ha);
		add_row(2, 1'b1, K_IDLE, K_DATA, K_DATA, K_DATA, 1'b1, 4'h3);
		// second A burst word keeps its eop
		add_row(3, 1'b1, K_BA, K_DATA, K_BA, K_DATA, 1'b1, 4'h6);
		add_row(3, 1'b1, K_BA, K_BA, K_DATA, K_DATA, 1'b0, 4'h9);
		add_row(3, 1'b1, K_DATA, K_BO, K_DATA, K_DATA, 1'b1, 4'h4);
		add_row(4, 1'b1, K_BB, K_DATA, K_DATA, K_DATA, 1'b1, 4'h0);
		add_row(4, 1'b0, K_DATA, K_DATA, K_DATA, K_DATA, 1'b0, 4'h0);
		add_row(4, 1'b1, K_DATA, K_DATA, K_DATA, K_DATA, 1'b0, 4'h0);
		add_row(4, 1'b0, K_IDLE, K_IDLE, K_IDLE, K_IDLE, 1'b0, 4'hc);
		add_row(4, 1'b1, K_DATA, K_DATA, K_IDLE, K_DATA, 1'b0, 4'h2);
		// groups of 2, 1, 3, 2, 4, 2, 2, 1 words for A
		add_row(5, 1'b1, K_BA, K_DATA, K_BO, K_DATA, 1'b1, 4'h1);
		add_row(5, 1'b1, K_BA, K_BO, K_DATA, K_DATA, 1'b0, 4'h2);
		add_row(5, 1'b1, K_BA, K_DATA, K_DATA, K_BO, 1'b1, 4'h3);
		add_row(5, 1'b1, K_BO, K_BA, K_DATA, K_BO, 1'b0, 4'h4);
		add_row(5, 1'b1, K_BA, K_DATA, K_DATA, K_DATA, 1'b1, 4'h5);
		add_row(5, 1'b1, K_DATA, K_IDLE, K_BA, K_IDLE, 1'b0, 4'h6);
		add_row(5, 1'b1, K_BB, K_DATA, K_BA, K_DATA, 1'b1, 4'h8);
		add_row(5, 1'b1, K_DATA, K_IDLE, K_DATA, K_DATA, 1'b0, 4'h9);
	endtask

	// data words get random payload with the control flag clear
	function automatic lane_word_t make_word(input logic [2:0] kind, input logic sop,
		input logic [3:0] eop);
		lane_word_t w;
		w = '0;
		if (kind == K_DATA) begin
			w = {1'b0, $urandom(), $urandom()};
		end else begin
			w[BIT_CTRL] = 1'b1;
			w[BIT_TYPE1] = 1'b1;
			w[BIT_TYPE0] = (kind != K_IDLE);
			w[BIT_SOP] = sop;
			w[EOP_HI:EOP_LO] = eop;
			case (kind)
				K_BA: w[CHAN_HI:CHAN_LO] = CHAN_A;
				K_BB: w[CHAN_HI:CHAN_LO] = CHAN_B;
				K_BO: w[CHAN_HI:CHAN_LO] = CHAN_OTHER;
				default: w[CHAN_HI:CHAN_LO] = '0;
			endcase
		end
		return w;
	endfunction

	////////////////////
	// drive helpers
	////////////////////

	task automatic drive_row(input int r);
		lane_group_t grp;
		for (int i = 0; i < NUM_WORDS; i++) begin
			grp[i] = make_word(row_kind[r][i], row_sop[r], row_eop[r]);
		end
		@(negedge clk);
		lanes_valid = row_valid[r];
		lanes = grp;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge clk);
			lanes_valid = 1'b0;
			lanes = '0;
		end
	endtask

	// done is updated on the falling edge, read it on the rising edge
	task automatic wait_drained(output logic timed_out);
		int waited;
		waited = 0;
		@(posedge clk);
		while (!done && waited < DRAIN_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		timed_out = !done;
	endtask

	rx_channel_demux uut (
		.clk          (clk),
		.arst         (arst),
		.lanes_valid  (lanes_valid),
		.lanes        (lanes),
		.page_a_valid (page_a_valid),
		.page_a       (page_a),
		.page_b_valid (page_b_valid),
		.page_b       (page_b)
	);

	demux_checker u_check (
		.clk          (clk),
		.arst         (arst),
		.lanes_valid  (lanes_valid),
		.lanes        (lanes),
		.page_a_valid (page_a_valid),
		.page_a       (page_a),
		.page_b_valid (page_b_valid),
		.page_b       (page_b),
		.done         (done),
		.error_count  (error_count),
		.word_count   (word_count)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		int   row;
		int   errors_before;
		int   words_before;
		logic timed_out;
		void'($urandom(32'hba7c_91f4));
		arst = 1'b1;
		lanes_valid = 1'b0;
		lanes = '0;
		build_table();
		repeat (2) @(negedge clk);
		arst = 1'b0;
		timed_out = 1'b0;
		row = 0;
		for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
			errors_before = error_count;
			words_before = word_count;
			while (row < row_total && row_test[row] == t) begin
				drive_row(row);
				row++;
			end
			// let the pipeline and the packer empty out
			idle_cycles(8);
			wait_drained(timed_out);
			if (timed_out) begin
				$display("test %0d: four or more expected words still unpaged after %0d cycles",
					t + 1, DRAIN_LIMIT);
			end
			$display("test %0d (%s): %0d words checked, %0d errors", t + 1, test_name[t],
				word_count - words_before, error_count - errors_before);
		end
		$display("%0d rows, %0d words checked, %0d errors", row, word_count, error_count);
		if (error_count == 0 && !timed_out) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- verif/demux_checker.sv
////////////////////
// scoreboard for the receive channel demux
// follows the ownership rule word by word on the lane input
// and compares every page word of channels A and B in order
////////////////////

module demux_checker
	import ilkn_rx_pkg::*;
(
	input  logic        clk,
	input  logic        arst,
	input  logic        lanes_valid,
	input  lane_group_t lanes,
	input  logic        page_a_valid,
	input  lane_group_t page_a,
	input  logic        page_b_valid,
	input  lane_group_t page_b,
	output logic        done,
	output int          error_count,
	output int          word_count
);
	timeunit 1ns;
	timeprecision 100ps;

	// expected masked words per channel, index 0 is A
	lane_word_t  exp_q [2][$];
	logic        own [2];
	logic        valid_smp;
	lane_group_t lanes_smp;

	function automatic chan_id_t chan_for(input int ch);
		return (ch == 0) ? CHAN_A : CHAN_B;
	endfunction

	// one group in arrival order, slot 3 first
	// stop words never join the queue, so only the eop mask shows up
	task automatic follow_group(input int ch, input lane_group_t grp);
		lane_word_t w;
		logic       start;
		logic       stop;
		logic       own_now;
		for (int i = NUM_WORDS - 1; i >= 0; i--) begin
			w = grp[i];
			start = w[BIT_CTRL] && w[BIT_TYPE1] && w[BIT_TYPE0] &&
				(w[CHAN_HI:CHAN_LO] == chan_for(ch));
			stop = w[BIT_CTRL] && w[BIT_TYPE1] && !start;
			own_now = start || (own[ch] && !stop);
			// first owned word after a gap loses its eop field
			if (own_now && !own[ch]) begin
				w[EOP_HI:EOP_LO] = '0;
			end
			if (own_now) begin
				exp_q[ch].push_back(w);
			end
			own[ch] = own_now;
		end
	endtask

	// page slot 3 holds the oldest word
	task automatic check_page(input int ch, input lane_group_t pg);
		string      name;
		lane_word_t want;
		name = (ch == 0) ? "page_a" : "page_b";
		if (exp_q[ch].size() < NUM_WORDS) begin
			$display("%s_valid strobed at %0t ns with only %0d words expected",
				name, $time, exp_q[ch].size());
			error_count++;
		end else begin
			for (int k = 0; k < NUM_WORDS; k++) begin
				want = exp_q[ch].pop_front();
				word_count++;
				if (pg[NUM_WORDS-1-k] !== want) begin
					$display("error at %0t ns: %s[%0d] expected %h, got %h",
						$time, name, NUM_WORDS - 1 - k, want, pg[NUM_WORDS-1-k]);
					error_count++;
				end
			end
		end
	endtask

	// lanes settle after the falling-edge drive, take them on the rising edge
	always @(posedge clk) begin
		valid_smp = lanes_valid;
		lanes_smp = lanes;
	end

	// pages are checked before this cycle's group goes into the queues
	always @(negedge clk or posedge arst) begin
		if (arst) begin
			own[0] = 1'b0;
			own[1] = 1'b0;
			exp_q[0].delete();
			exp_q[1].delete();
			error_count = 0;
			word_count = 0;
			done = 1'b1;
		end else begin
			if (page_a_valid) begin
				check_page(0, page_a);
			end
			if (page_b_valid) begin
				check_page(1, page_b);
			end
			if (valid_smp) begin
				follow_group(0, lanes_smp);
				follow_group(1, lanes_smp);
			end
			done = (exp_q[0].size() < NUM_WORDS) && (exp_q[1].size() < NUM_WORDS);
		end
	end

endmodule

//--- logic/rx_channel_demux.sv
////////////////////
// receive channel demux top, channels A and B
// each channel is a filter followed by a page packer
////////////////////

module rx_channel_demux
	import ilkn_rx_pkg::*;
(
	input  logic        clk,
	input  logic        arst,
	input  logic        lanes_valid,
	input  lane_group_t lanes,
	output logic        page_a_valid,
	output lane_group_t page_a,
	output logic        page_b_valid,
	output lane_group_t page_b
);

	// filter to packer, per channel
	word_count_t chan_count_a;
	lane_group_t chan_words_a;
	word_count_t chan_count_b;
	lane_group_t chan_words_b;

	////////////////////
	// channel A
	////////////////////

	channel_filter #(.chan_num(CHAN_A)) u_filter_a (
		.clk         (clk),
		.arst        (arst),
		.lanes_valid (lanes_valid),
		.lanes       (lanes),
		.chan_count  (chan_count_a),
		.chan_words  (chan_words_a)
	);

	word_packer u_packer_a (
		.clk        (clk),
		.arst       (arst),
		.chan_count (chan_count_a),
		.chan_words (chan_words_a),
		.page_valid (page_a_valid),
		.page       (page_a)
	);

	////////////////////
	// channel B
	////////////////////

	channel_filter #(.chan_num(CHAN_B)) u_filter_b (
		.clk         (clk),
		.arst        (arst),
		.lanes_valid (lanes_valid),
		.lanes       (lanes),
		.chan_count  (chan_count_b),
		.chan_words  (chan_words_b)
	);

	word_packer u_packer_b (
		.clk        (clk),
		.arst       (arst),
		.chan_count (chan_count_b),
		.chan_words (chan_words_b),
		.page_valid (page_b_valid),
		.page       (page_b)
	);

endmodule

//--- logic/word_packer.sv
////////////////////
// packs variable groups of channel words into full four-word pages
// page_valid is a one-cycle strobe, page is valid with it
// up to three leftover words wait for the next group
////////////////////

module word_packer
	import ilkn_rx_pkg::*;
(
	input  logic        clk,
	input  logic        arst,
	input  word_count_t chan_count,
	input  lane_group_t chan_words,
	output logic        page_valid,
	output lane_group_t page
);

	// leftover words in arrival order, hold[0] is the oldest
	lane_word_t  hold [NUM_WORDS-1];
	// leftovers followed by the new words
	lane_word_t  merged [2*NUM_WORDS-1];
	word_count_t fill;
	word_count_t total;
	logic        page_full;

	////////////////////
	// merge
	////////////////////

	always_comb begin
		total = fill + chan_count;
		page_full = (total >= word_count_t'(NUM_WORDS));
	end

	// new word k goes right after the fill leftovers
	// incoming slot 3 is the first arrival
	always_comb begin
		for (int p = 0; p < 2 * NUM_WORDS - 1; p++) begin
			merged[p] = '0;
			for (int h = 0; h < NUM_WORDS - 1; h++) begin
				if (p == h && word_count_t'(h) < fill) begin
					merged[p] = hold[h];
				end
			end
			for (int k = 0; k < NUM_WORDS; k++) begin
				if (p == int'(fill) + k && word_count_t'(k) < chan_count) begin
					merged[p] = chan_words[NUM_WORDS-1-k];
				end
			end
		end
	end

	////////////////////
	// page and leftovers
	////////////////////

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			fill <= '0;
			page_valid <= 1'b0;
		end else begin
			page_valid <= page_full;
			if (page_full) begin
				fill <= total - word_count_t'(NUM_WORDS);
			end else begin
				fill <= total;
			end
		end
	end

	// oldest four words form the page, overflow moves down to hold
	always_ff @(posedge clk) begin
		if (page_full) begin
			for (int k = 0; k < NUM_WORDS; k++) begin
				page[NUM_WORDS-1-k] <= merged[k];
			end
		end
		for (int h = 0; h < NUM_WORDS - 1; h++) begin
			if (page_full) begin
				hold[h] <= merged[h+NUM_WORDS];
			end else begin
				hold[h] <= merged[h];
			end
		end
	end

	////////////////////
	// checks
	////////////////////

	// a full page always leaves, so at most three words wait
	a_fill_max : assert property (@(posedge clk) disable iff (arst)
		fill <= word_count_t'(NUM_WORDS - 1))
		else $error("packer fill %0d above %0d", fill, NUM_WORDS - 1);

endmodule

//--- logic/channel_filter.sv
////////////////////
// pulls one channel out of the four-word lane stream
// six register stages, chan_words and chan_count follow lanes by 6 clocks
// owned words come out compacted toward slot 3 in arrival order
////////////////////

module channel_filter
	import ilkn_rx_pkg::*;
#(
	parameter chan_id_t chan_num = CHAN_A
) (
	input  logic        clk,
	input  logic        arst,
	input  logic        lanes_valid,
	input  lane_group_t lanes,
	output word_count_t chan_count,
	output lane_group_t chan_words
);

	////////////////////
	// stage 1 input capture
	////////////////////

	logic        valid_s1;
	lane_group_t words_s1;

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			valid_s1 <= 1'b0;
		end else begin
			valid_s1 <= lanes_valid;
		end
	end

	always_ff @(posedge clk) begin
		words_s1 <= lanes;
	end

	////////////////////
	// stage 2 start and stop marks
	////////////////////

	logic [NUM_WORDS-1:0] is_burst;
	logic [NUM_WORDS-1:0] has_eop;
	logic [NUM_WORDS-1:0] chan_hit;
	logic [NUM_WORDS-1:0] start_s2;
	logic [NUM_WORDS-1:0] stop_s2;
	logic                 valid_s2;
	lane_group_t          words_s2;

	// only burst control has a valid channel field
	// burst and idle control both close the previous data
	always_comb begin
		for (int i = 0; i < NUM_WORDS; i++) begin
			is_burst[i] = words_s1[i][BIT_CTRL] & words_s1[i][BIT_TYPE1] &
				words_s1[i][BIT_TYPE0];
			has_eop[i] = words_s1[i][BIT_CTRL] & words_s1[i][BIT_TYPE1];
			chan_hit[i] = (words_s1[i][CHAN_HI:CHAN_LO] == chan_num);
		end
	end

	// a burst word restarting our own channel is not a stop
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			start_s2 <= '0;
			stop_s2 <= '0;
			valid_s2 <= 1'b0;
		end else begin
			start_s2 <= is_burst & chan_hit;
			stop_s2 <= has_eop & ~(is_burst & chan_hit);
			valid_s2 <= valid_s1;
		end
	end

	always_ff @(posedge clk) begin
		words_s2 <= words_s1;
	end

	////////////////////
	// stage 3 ownership chain
	////////////////////

	logic [NUM_WORDS-1:0] own_c;
	logic [NUM_WORDS-1:0] own_s3;
	logic                 carry;
	// ownership after the last valid group, and the value before it
	logic                 held;
	logic                 prev_held;
	lane_group_t          words_sop;
	lane_group_t          words_s3;

	// walk in arrival order, slot 3 first
	always_comb begin
		carry = held;
		for (int i = NUM_WORDS - 1; i >= 0; i--) begin
			own_c[i] = start_s2[i] | (carry & ~stop_s2[i]);
			carry = own_c[i];
		end
	end

	// sop on a stop word belongs to some other channel
	always_comb begin
		for (int i = 0; i < NUM_WORDS; i++) begin
			words_sop[i] = words_s2[i];
			if (stop_s2[i]) begin
				words_sop[i][BIT_SOP] = 1'b0;
			end
		end
	end

	// invalid groups own nothing and leave the held state alone
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			own_s3 <= '0;
			held <= 1'b0;
			prev_held <= 1'b0;
		end else begin
			own_s3 <= own_c & {NUM_WORDS{valid_s2}};
			if (valid_s2) begin
				held <= carry;
				prev_held <= held;
			end
		end
	end

	always_ff @(posedge clk) begin
		words_s3 <= words_sop;
	end

	////////////////////
	// stage 4 eop mask and counts
	////////////////////

	logic [NUM_WORDS-1:0] first_c;
	logic [NUM_WORDS-1:0] own_s4;
	word_count_t          pop_c;
	word_count_t          before_c [NUM_WORDS];
	word_count_t          before_s4 [NUM_WORDS];
	word_count_t          count_s4;
	lane_group_t          words_eop;
	lane_group_t          words_s4;

	// first owned word after a gap, slot 3 looks back across groups
	always_comb begin
		first_c[NUM_WORDS-1] = own_s3[NUM_WORDS-1] & ~prev_held;
		for (int i = 0; i < NUM_WORDS - 1; i++) begin
			first_c[i] = own_s3[i] & ~own_s3[i+1];
		end
	end

	// eop on a burst start refers to data before the burst
	always_comb begin
		for (int i = 0; i < NUM_WORDS; i++) begin
			words_eop[i] = words_s3[i];
			if (first_c[i]) begin
				words_eop[i][EOP_HI:EOP_LO] = '0;
			end
		end
	end

	// population count, and per slot the number of owned words ahead of it
	always_comb begin
		pop_c = '0;
		for (int i = NUM_WORDS - 1; i >= 0; i--) begin
			before_c[i] = pop_c;
			pop_c = pop_c + word_count_t'(own_s3[i]);
		end
	end

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			own_s4 <= '0;
			count_s4 <= '0;
			before_s4 <= '{default: '0};
		end else begin
			own_s4 <= own_s3;
			count_s4 <= pop_c;
			before_s4 <= before_c;
		end
	end

	always_ff @(posedge clk) begin
		words_s4 <= words_eop;
	end

	////////////////////
	// stage 5 compaction
	////////////////////

	lane_group_t sel_c;
	lane_group_t words_s5;
	word_count_t count_s5;

	// output position k takes the owned word with k owned words ahead
	// positions with no such word keep junk, cleared in stage 6
	always_comb begin
		for (int k = 0; k < NUM_WORDS; k++) begin
			sel_c[NUM_WORDS-1-k] = words_s4[NUM_WORDS-1-k];
			for (int i = 0; i < NUM_WORDS; i++) begin
				if (own_s4[i] && before_s4[i] == word_count_t'(k)) begin
					sel_c[NUM_WORDS-1-k] = words_s4[i];
				end
			end
		end
	end

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			count_s5 <= '0;
		end else begin
			count_s5 <= count_s4;
		end
	end

	always_ff @(posedge clk) begin
		words_s5 <= sel_c;
	end

	////////////////////
	// stage 6 output
	////////////////////

	lane_group_t keep_c;

	// top count slots survive, the rest go to zero
	always_comb begin
		for (int j = 0; j < NUM_WORDS; j++) begin
			if (word_count_t'(NUM_WORDS - 1 - j) < count_s5) begin
				keep_c[j] = words_s5[j];
			end else begin
				keep_c[j] = '0;
			end
		end
	end

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			chan_count <= '0;
		end else begin
			chan_count <= count_s5;
		end
	end

	always_ff @(posedge clk) begin
		chan_words <= keep_c;
	end

	////////////////////
	// checks
	////////////////////

	for (genvar g = 0; g < NUM_WORDS; g++) begin : g_chk
		// a stop seen in stage 2 lands in stage 3 as a control word
		a_stop_ctrl : assert property (@(posedge clk) disable iff (arst)
			$past(stop_s2[g]) |-> words_s3[g][BIT_CTRL])
			else $error("stop word in slot %0d is not a control word", g);

		// ownership can only begin on a burst control word
		a_first_ctrl : assert property (@(posedge clk) disable iff (arst)
			first_c[g] |-> words_s3[g][BIT_CTRL])
			else $error("first owned word in slot %0d is not a control word", g);
	end

	a_count_max : assert property (@(posedge clk) disable iff (arst)
		chan_count <= word_count_t'(NUM_WORDS))
		else $error("chan_count %0d above %0d", chan_count, NUM_WORDS);

endmodule

//--- logic/ilkn_rx_pkg.sv
////////////////////
// shared definitions for the receive channel demultiplexer
// lane word field positions, widths, word types and channel numbers
// imported by every RTL module of the demux
////////////////////

package ilkn_rx_pkg;

	// words presented per clock, slice 3 arrives first
	localparam int NUM_WORDS = 4;
	// 64 payload bits plus the control flag
	localparam int WORD_W = 65;

	////////////////////
	// word format
	////////////////////

	// set on any control word
	localparam int BIT_CTRL = 64;
	// burst control and idle control both carry this one
	localparam int BIT_TYPE1 = 63;
	// only burst control words
	localparam int BIT_TYPE0 = 62;
	// start of packet, meaningful on burst control
	localparam int BIT_SOP = 61;
	// end of packet field, refers to the data before the word
	localparam int EOP_HI = 60;
	localparam int EOP_LO = 57;
	// channel number inside a burst control word
	localparam int CHAN_HI = 39;
	localparam int CHAN_LO = 32;

	////////////////////
	// types
	////////////////////

	typedef logic [WORD_W-1:0] lane_word_t;
	// most significant slice is the first arrival
	typedef lane_word_t [NUM_WORDS-1:0] lane_group_t;
	// 0 to 4 valid words
	typedef logic [2:0] word_count_t;
	typedef logic [CHAN_HI-CHAN_LO:0] chan_id_t;

	// channels pulled out at the top level
	localparam chan_id_t CHAN_A = 8'h01;
	localparam chan_id_t CHAN_B = 8'h02;

endpackage
